// File: common/smem_queue_pkg.sv
//--------------------------------------------------------------------------
// shared types for the read recirculation queue of the SMEM search engine
// status codes, meaningful field widths, the forward read state, the
// compact stored entry and the DRAM occurrence bundle
// import with a wildcard inside a module body, scoped names in port lists
//--------------------------------------------------------------------------
package smem_queue_pkg;

	// read phases carried on every status field
	typedef enum logic [5:0] {
		F_INIT  = 6'h00,	// first pass, no query needed yet
		F_RUN   = 6'h01,
		F_BREAK = 6'h02,	// forward extension stopped
		BCK_INI = 6'h04,
		BCK_RUN = 6'h05,
		BCK_END = 6'h06,
		DONE    = 6'h20,
		BUBBLE  = 6'h30	// empty slot in the pipeline
	} status_t;

	typedef logic [9:0]  read_num_t;
	typedef logic [6:0]  pos_t;	// ptr_curr, forward_i, min_intv, backward_x
	typedef logic [7:0]  query_t;	// query base or query position
	typedef logic [63:0] bwt_word_t;
	typedef logic [32:0] intv_t;	// interval as kept in the queue
	typedef logic [13:0] info_t;	// info bits 38:32 over 6:0

	//----------------------------------------------------------------------
	// pipeline side
	//----------------------------------------------------------------------

	// full read state, 308 bits
	typedef struct packed {
		status_t   status;
		pos_t      ptr_curr;
		read_num_t read_num;
		bwt_word_t ik_x0;
		bwt_word_t ik_x1;
		bwt_word_t ik_x2;
		bwt_word_t ik_info;
		pos_t      forward_i;
		pos_t      min_intv;
		pos_t      backward_x;
		query_t    query;
	} fwd_state_t;

	// what the read ring stores, 165 bits
	typedef struct packed {
		status_t   status;
		pos_t      ptr_curr;
		read_num_t read_num;
		intv_t     ik_x0;
		intv_t     ik_x1;
		intv_t     ik_x2;
		info_t     ik_info;
		pos_t      forward_i;
		pos_t      min_intv;
		query_t    query;
		pos_t      backward_x;
	} queue_entry_t;

	// occurrence counts from DRAM, 768 bits
	typedef struct packed {
		logic [3:0][31:0] cnt_a;
		logic [3:0][63:0] cnt_b;
		logic [3:0][31:0] cntl_a;
		logic [3:0][63:0] cntl_b;
	} occ_bundle_t;

	typedef struct packed {
		read_num_t read_num;
		bwt_word_t ik_x0;
		bwt_word_t ik_x1;
		bwt_word_t ik_x2;
		bwt_word_t ik_info;
		pos_t      forward_i;
	} new_read_t;

	// one request on the shared query RAM port
	typedef struct packed {
		query_t    position;
		read_num_t read_num;
		status_t   status;
	} query_req_t;

	//----------------------------------------------------------------------
	// constants
	//----------------------------------------------------------------------
	localparam occ_bundle_t OCC_FILL = occ_bundle_t'({192{4'h1}});
	localparam query_req_t QUERY_IDLE = query_req_t'('1);

endpackage

// File: design/entry_ring.sv
//--------------------------------------------------------------------------
// circular buffer used for both the read queue and the DRAM response FIFO
// write strobe stores at the tail, pop strobe drops the head
// head word and empty flag are combinational; DEPTH must be a power of two
//--------------------------------------------------------------------------
module entry_ring #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             Clk_32UI,
	input  logic             reset_n,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW:0] wr_ptr;	// extra msb tells full from empty
	logic [AW:0] rd_ptr;
	logic full;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign rd_data = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge Clk_32UI) begin
		if (wr_en) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// upstream must never run the ring past its depth
	a_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		wr_en |-> !full);

	// the dispatcher only pops what it has seen at the head
	a_no_underflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		rd_en |-> !empty);

endmodule

// File: design/query_fetch/query_fetch.sv
//--------------------------------------------------------------------------
// query port grant and the delay line that waits for the query RAM
// forward requester has priority, backward takes the port when forward idles
// each returning read is packed with its new query base into a queue entry
// and written into the read ring QUERY_LATENCY + 1 edges after sampling
//--------------------------------------------------------------------------
module query_fetch #(
	parameter int QUERY_LATENCY = 3
) (
	input  logic                          Clk_32UI,
	input  smem_queue_pkg::fwd_state_t    fwd_in,
	input  smem_queue_pkg::query_t        next_query_position,
	input  smem_queue_pkg::status_t       status_B,
	input  smem_queue_pkg::read_num_t     read_num_B,
	input  smem_queue_pkg::query_t        output_c_B,
	input  smem_queue_pkg::query_t        query_data,
	output smem_queue_pkg::query_req_t    query_req,
	output smem_queue_pkg::queue_entry_t  entry,
	output logic                          entry_write
);

	import smem_queue_pkg::*;

	logic fwd_grant;
	logic bck_grant;
	fwd_state_t delay_q [QUERY_LATENCY];
	fwd_state_t aligned;	// lines up with query_data

	//----------------------------------------------------------------------
	// query port, fixed priority
	//----------------------------------------------------------------------
	assign fwd_grant = (fwd_in.status != BUBBLE) && (fwd_in.status != F_BREAK);
	assign bck_grant = (status_B != BUBBLE) && (status_B != BCK_END);

	always_comb begin
		if (fwd_grant) begin
			query_req = '{position: next_query_position,
				read_num: fwd_in.read_num, status: fwd_in.status};
		end else if (bck_grant) begin
			query_req = '{position: output_c_B, read_num: read_num_B, status: status_B};
		end else begin
			query_req = QUERY_IDLE;
		end
	end

	//----------------------------------------------------------------------
	// latency matching, free running
	//----------------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		delay_q[0] <= fwd_in;
		for (int i = 1; i < QUERY_LATENCY; i++) begin
			delay_q[i] <= delay_q[i-1];
		end
	end

	assign aligned = delay_q[QUERY_LATENCY-1];

	// pack into the stored form, high interval bits are dropped
	always_ff @(posedge Clk_32UI) begin
		entry.status     <= aligned.status;
		entry.ptr_curr   <= aligned.ptr_curr;
		entry.read_num   <= aligned.read_num;
		entry.ik_x0      <= aligned.ik_x0[32:0];
		entry.ik_x1      <= aligned.ik_x1[32:0];
		entry.ik_x2      <= aligned.ik_x2[32:0];
		entry.ik_info    <= {aligned.ik_info[38:32], aligned.ik_info[6:0]};
		entry.forward_i  <= aligned.forward_i;
		entry.min_intv   <= aligned.min_intv;
		entry.query      <= query_data;	// base fetched for this read
		entry.backward_x <= aligned.backward_x;
		entry_write      <= aligned.status inside {F_INIT, F_RUN, F_BREAK};
	end

	// an active forward read always owns the port
	a_fwd_not_idle: assert property (@(posedge Clk_32UI)
		fwd_grant |-> query_req != QUERY_IDLE);

endmodule

// File: design/read_dispatch/read_dispatch.sv
//--------------------------------------------------------------------------
// head decision for the read queue, new read requests to the loader
// and the registered outputs back into the forward pipeline
// one decision per edge without stall; under stall everything holds
//--------------------------------------------------------------------------
module read_dispatch (
	input  logic                          Clk_32UI,
	input  logic                          reset_n,
	input  logic                          stall,
	input  smem_queue_pkg::queue_entry_t  head_entry,
	input  logic                          read_empty,
	input  smem_queue_pkg::occ_bundle_t   head_occ,
	input  logic                          resp_empty,
	input  logic                          new_read_valid,
	input  logic                          load_done,
	input  smem_queue_pkg::new_read_t     new_read_in,
	output logic                          read_pop,
	output logic                          resp_pop,
	output logic                          new_read,
	output smem_queue_pkg::fwd_state_t    fwd_out,
	output smem_queue_pkg::occ_bundle_t   occ_out
);

	import smem_queue_pkg::*;

	logic head_break;	// broken read waiting at the head
	logic pair_ready;	// head read plus a DRAM bundle
	fwd_state_t fwd_next;
	occ_bundle_t occ_next;

	// back to full width, info bits land at 38:32 and 6:0
	function automatic fwd_state_t unpack_entry(queue_entry_t e);
		fwd_state_t f;
		f.status     = e.status;
		f.ptr_curr   = e.ptr_curr;
		f.read_num   = e.read_num;
		f.ik_x0      = {31'b0, e.ik_x0};
		f.ik_x1      = {31'b0, e.ik_x1};
		f.ik_x2      = {31'b0, e.ik_x2};
		f.ik_info    = {25'b0, e.ik_info[13:7], 25'b0, e.ik_info[6:0]};
		f.forward_i  = e.forward_i;
		f.min_intv   = e.min_intv;
		f.backward_x = e.backward_x;
		f.query      = e.query;
		return f;
	endfunction

	//----------------------------------------------------------------------
	// decision
	//----------------------------------------------------------------------
	assign head_break = !read_empty && (head_entry.status == F_BREAK);
	assign pair_ready = !head_break && !read_empty && !resp_empty;

	assign read_pop = !stall && (head_break || pair_ready);
	assign resp_pop = !stall && pair_ready;

	// a break at the head takes the slot, the loader keeps its read
	assign new_read = load_done && new_read_valid && resp_empty && !stall && !head_break;

	always_comb begin
		fwd_next = '1;	// bubble fields
		fwd_next.status = BUBBLE;
		occ_next = OCC_FILL;
		if (head_break) begin
			fwd_next = unpack_entry(head_entry);
		end else if (pair_ready) begin
			fwd_next = unpack_entry(head_entry);
			occ_next = head_occ;
		end else if (new_read) begin
			fwd_next.status     = F_INIT;
			fwd_next.ptr_curr   = '0;
			fwd_next.read_num   = new_read_in.read_num;
			fwd_next.ik_x0      = new_read_in.ik_x0;
			fwd_next.ik_x1      = new_read_in.ik_x1;
			fwd_next.ik_x2      = new_read_in.ik_x2;
			fwd_next.ik_info    = new_read_in.ik_info;
			fwd_next.forward_i  = new_read_in.forward_i + 7'd1;
			fwd_next.backward_x = new_read_in.forward_i;
			fwd_next.min_intv   = 7'd1;
			fwd_next.query      = '0;	// first round has no query
		end
		// response with an empty read ring also ends here as a bubble
	end

	//----------------------------------------------------------------------
	// output registers
	//----------------------------------------------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			fwd_out.status <= BUBBLE;
			occ_out <= OCC_FILL;
		end else if (!stall) begin
			fwd_out <= fwd_next;
			occ_out <= occ_next;
		end
	end

	a_pop_or_inject: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		!(read_pop && new_read));

endmodule

// File: design/smem_queue.sv
//--------------------------------------------------------------------------
// read recirculation queue, top level
// query fetch feeds the read ring, DRAM bundles go to the response ring,
// the dispatcher sends reads back out to the forward pipeline
//--------------------------------------------------------------------------
module smem_queue #(
	parameter int QUERY_LATENCY = 3,
	parameter int READ_DEPTH    = 256,
	parameter int RESP_DEPTH    = 32
) (
	input  logic                        Clk_32UI,
	input  logic                        reset_n,
	input  logic                        stall,
	input  smem_queue_pkg::fwd_state_t  fwd_in,
	input  smem_queue_pkg::query_t      next_query_position,
	input  smem_queue_pkg::status_t     status_B,
	input  smem_queue_pkg::read_num_t   read_num_B,
	input  smem_queue_pkg::query_t      output_c_B,
	input  logic                        dram_get,
	input  smem_queue_pkg::occ_bundle_t occ_in,
	input  logic                        new_read_valid,
	input  logic                        load_done,
	input  smem_queue_pkg::new_read_t   new_read_in,
	input  smem_queue_pkg::query_t      query_data,
	output smem_queue_pkg::query_req_t  query_req,
	output logic                        new_read,
	output smem_queue_pkg::fwd_state_t  fwd_out,
	output smem_queue_pkg::occ_bundle_t occ_out
);

	import smem_queue_pkg::*;

	queue_entry_t entry;	// packed read from the delay line
	logic entry_write;
	queue_entry_t head_entry;
	logic read_empty;
	logic read_pop;
	occ_bundle_t head_occ;
	logic resp_empty;
	logic resp_pop;

	query_fetch #(
		.QUERY_LATENCY(QUERY_LATENCY)
	) u_query_fetch (
		.Clk_32UI            (Clk_32UI),
		.fwd_in              (fwd_in),
		.next_query_position (next_query_position),
		.status_B            (status_B),
		.read_num_B          (read_num_B),
		.output_c_B          (output_c_B),
		.query_data          (query_data),
		.query_req           (query_req),
		.entry               (entry),
		.entry_write         (entry_write)
	);

	// parked reads
	entry_ring #(
		.WIDTH($bits(queue_entry_t)),
		.DEPTH(READ_DEPTH)
	) read_ring (
		.Clk_32UI (Clk_32UI),
		.reset_n  (reset_n),
		.wr_en    (entry_write),	// not held off by stall
		.wr_data  (entry),
		.rd_en    (read_pop),
		.rd_data  (head_entry),
		.empty    (read_empty)
	);

	// occurrence bundles from DRAM
	entry_ring #(
		.WIDTH($bits(occ_bundle_t)),
		.DEPTH(RESP_DEPTH)
	) resp_ring (
		.Clk_32UI (Clk_32UI),
		.reset_n  (reset_n),
		.wr_en    (dram_get),
		.wr_data  (occ_in),
		.rd_en    (resp_pop),
		.rd_data  (head_occ),
		.empty    (resp_empty)
	);

	read_dispatch u_read_dispatch (
		.Clk_32UI       (Clk_32UI),
		.reset_n        (reset_n),
		.stall          (stall),
		.head_entry     (head_entry),
		.read_empty     (read_empty),
		.head_occ       (head_occ),
		.resp_empty     (resp_empty),
		.new_read_valid (new_read_valid),
		.load_done      (load_done),
		.new_read_in    (new_read_in),
		.read_pop       (read_pop),
		.resp_pop       (resp_pop),
		.new_read       (new_read),
		.fwd_out        (fwd_out),
		.occ_out        (occ_out)
	);

endmodule

// File: dv/smem_queue_checks.sv
//--------------------------------------------------------------------------
// checker for the read recirculation queue, watches DUT ports only
// keeps the expected reads and DRAM bundles in push order and compares
// every dispatch, injection, stall hold and query port grant
//--------------------------------------------------------------------------
module smem_queue_checks (
	input  logic                        Clk_32UI,
	input  logic                        reset_n,
	input  logic                        stall,
	input  smem_queue_pkg::fwd_state_t  fwd_in,
	input  smem_queue_pkg::query_t      next_query_position,
	input  smem_queue_pkg::status_t     status_B,
	input  smem_queue_pkg::read_num_t   read_num_B,
	input  smem_queue_pkg::query_t      output_c_B,
	input  logic                        dram_get,
	input  smem_queue_pkg::occ_bundle_t occ_in,
	input  logic                        new_read_valid,
	input  logic                        load_done,
	input  smem_queue_pkg::new_read_t   new_read_in,
	input  smem_queue_pkg::query_req_t  query_req,
	input  logic                        new_read,
	input  smem_queue_pkg::fwd_state_t  fwd_out,
	input  smem_queue_pkg::occ_bundle_t occ_out,
	output logic                        error_seen,
	output int                          pending_reads
);

	timeunit 1ns;
	timeprecision 1ps;

	import smem_queue_pkg::*;

	localparam bwt_word_t INTV_MASK = 64'h0000_0001_ffff_ffff;
	localparam bwt_word_t INFO_MASK = 64'h0000_007f_0000_007f;	// bits 38:32 and 6:0

	fwd_state_t exp_q [$];	// reads in ring order
	occ_bundle_t occ_q [$];	// bundles in DRAM order
	fwd_state_t fwd_prev;
	occ_bundle_t occ_prev;
	new_read_t load_prev;
	logic stall_prev;
	logic inject_prev;
	int push_cnt;
	int push_cnt_prev;
	int pop_cnt;

	initial begin
		error_seen = 1'b0;
		pending_reads = 0;
	end

	task automatic report_mismatch(string name, logic [767:0] exp, logic [767:0] act);
		$display("mismatch %s expected %h actual %h", name, exp, act);
		error_seen = 1'b1;
	endtask

	task automatic report_failure(string what);
		$display("error: %s", what);
		error_seen = 1'b1;
	endtask

	// grant rule of the shared query port
	function automatic query_req_t expected_req(fwd_state_t f, query_t pos, status_t sb,
		read_num_t rb, query_t cb);
		query_req_t r;
		r = QUERY_IDLE;
		if (f.status != BUBBLE && f.status != F_BREAK)
			r = '{position: pos, read_num: f.read_num, status: f.status};
		else if (sb != BUBBLE && sb != BCK_END)
			r = '{position: cb, read_num: rb, status: sb};
		return r;
	endfunction

	// what should come back out after the round trip through the ring
	function automatic fwd_state_t stored_form(fwd_state_t f, query_req_t req);
		fwd_state_t e;
		e = f;
		e.ik_x0 = f.ik_x0 & INTV_MASK;
		e.ik_x1 = f.ik_x1 & INTV_MASK;
		e.ik_x2 = f.ik_x2 & INTV_MASK;
		e.ik_info = f.ik_info & INFO_MASK;
		e.query = query_t'(req.position + req.read_num);	// RAM model answer
		return e;
	endfunction

	function automatic fwd_state_t fresh_read(new_read_t n);
		fwd_state_t e;
		e.status = F_INIT;
		e.ptr_curr = '0;
		e.read_num = n.read_num;
		e.ik_x0 = n.ik_x0;
		e.ik_x1 = n.ik_x1;
		e.ik_x2 = n.ik_x2;
		e.ik_info = n.ik_info;
		e.forward_i = n.forward_i + 7'd1;
		e.min_intv = 7'd1;
		e.backward_x = n.forward_i;
		e.query = '0;
		return e;
	endfunction

	//----------------------------------------------------------------------
	// scoreboard, fwd_out seen here is the decision of the previous edge
	//----------------------------------------------------------------------
	always @(posedge Clk_32UI) begin
		fwd_state_t exp_f;
		occ_bundle_t exp_o;
		if (!reset_n) begin
			stall_prev <= 1'b0;
			inject_prev <= 1'b0;
			push_cnt <= 0;
			push_cnt_prev <= 0;
			pop_cnt <= 0;
			exp_q.delete();
			occ_q.delete();
		end else begin
			if (stall_prev) begin
				assert (fwd_out == fwd_prev) else report_mismatch("stall_fwd", fwd_prev, fwd_out);
				assert (occ_out == occ_prev) else report_mismatch("stall_occ", occ_prev, occ_out);
			end else if (inject_prev) begin
				exp_f = fresh_read(load_prev);
				assert (fwd_out == exp_f) else report_mismatch("inject_fwd", exp_f, fwd_out);
				assert (occ_out == OCC_FILL) else report_mismatch("inject_occ", OCC_FILL, occ_out);
				assert (push_cnt_prev == pop_cnt)
				else report_failure("new read raised while a DRAM response was waiting");
			end else if (fwd_out.status == BUBBLE) begin
				assert (occ_out == OCC_FILL) else report_mismatch("bubble_occ", OCC_FILL, occ_out);
			end else if (exp_q.size() == 0) begin
				report_failure("read dispatched while no read was expected");
			end else begin
				exp_f = exp_q.pop_front();
				assert (fwd_out == exp_f) else report_mismatch("dispatch_fwd", exp_f, fwd_out);
				if (exp_f.status == F_BREAK) begin
					assert (occ_out == OCC_FILL)
					else report_mismatch("break_occ", OCC_FILL, occ_out);
				end else if (occ_q.size() == 0) begin
					report_failure("read paired with a DRAM bundle that was never sent");
				end else begin
					exp_o = occ_q.pop_front();
					assert (occ_out == exp_o) else report_mismatch("pair_occ", exp_o, occ_out);
					pop_cnt <= pop_cnt + 1;
				end
			end
			if (fwd_in.status inside {F_INIT, F_RUN, F_BREAK})
				exp_q.push_back(stored_form(fwd_in, expected_req(fwd_in,
					next_query_position, status_B, read_num_B, output_c_B)));
			if (dram_get) begin
				occ_q.push_back(occ_in);
				push_cnt <= push_cnt + 1;
			end
			push_cnt_prev <= push_cnt;
			stall_prev <= stall;
			inject_prev <= new_read;
			load_prev <= new_read_in;
		end
		fwd_prev <= fwd_out;
		occ_prev <= occ_out;
		pending_reads <= exp_q.size();
	end

	//----------------------------------------------------------------------
	// cycle rules
	//----------------------------------------------------------------------
	a_grant: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		query_req == expected_req(fwd_in, next_query_position, status_B, read_num_B, output_c_B))
	else report_mismatch("query_grant",
		expected_req(fwd_in, next_query_position, status_B, read_num_B, output_c_B), query_req);

	a_stall_no_inject: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		stall |-> !new_read)
	else report_failure("new read raised under stall");

	a_inject_needs_loader: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		new_read |-> load_done && new_read_valid)
	else report_failure("new read raised without load_done and new_read_valid");

	a_reset_bubble: assert property (@(posedge Clk_32UI)
		$rose(reset_n) |-> fwd_out.status == BUBBLE)
	else report_mismatch("reset_bubble", BUBBLE, fwd_out.status);

endmodule

// File: dv/smem_queue_tb.sv
//--------------------------------------------------------------------------
// testbench for the read recirculation queue
// seeded random traffic from the forward pipeline, backward requester,
// DRAM and loader, a query RAM model and a watchdog; checking is done by
// the assertions of the checker instance
//--------------------------------------------------------------------------
module smem_queue_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import smem_queue_pkg::*;

	localparam int QUERY_LATENCY = 3;
	localparam int READ_DEPTH = 256;
	localparam int RESP_DEPTH = 32;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int RAND_CYCLES = 800;
	localparam int DRAIN_CYCLES = 600;	// upper bound for emptying the rings
	localparam int TEST_CYCLES = RESET_CYCLES + RAND_CYCLES + DRAIN_CYCLES;

	logic Clk_32UI;
	logic reset_n;
	logic stall;
	fwd_state_t fwd_in;
	query_t next_query_position;
	status_t status_B;
	read_num_t read_num_B;
	query_t output_c_B;
	logic dram_get;
	occ_bundle_t occ_in;
	logic new_read_valid;
	logic load_done;
	new_read_t new_read_in;
	query_t query_data;
	query_req_t query_req;
	logic new_read;
	fwd_state_t fwd_out;
	occ_bundle_t occ_out;

	logic error_seen;
	int pending_reads;
	int runs_sent;	// F_INIT and F_RUN reads that will want a bundle
	int bundles_sent;
	query_t answer_pipe [QUERY_LATENCY];

	always #(CLK_PERIOD / 2) Clk_32UI = ~Clk_32UI;

	smem_queue #(
		.QUERY_LATENCY(QUERY_LATENCY),
		.READ_DEPTH(READ_DEPTH),
		.RESP_DEPTH(RESP_DEPTH)
	) dut (.*);

	smem_queue_checks checks (.*);

	// query RAM, answer shows up QUERY_LATENCY edges after the request
	always @(posedge Clk_32UI) begin
		answer_pipe[0] <= query_t'(query_req.position + query_req.read_num);
		for (int i = 1; i < QUERY_LATENCY; i++)
			answer_pipe[i] <= answer_pipe[i-1];
	end

	always @(negedge Clk_32UI) query_data <= answer_pipe[QUERY_LATENCY-1];

	function automatic bwt_word_t random_word();
		return {$urandom, $urandom};
	endfunction

	function automatic status_t pick_fwd_status();
		int r;
		r = $urandom_range(0, 9);
		case (r)
			0, 1, 2: return F_RUN;
			3:       return F_INIT;
			4, 5:    return F_BREAK;
			6:       return BCK_RUN;	// takes the port but is not queued
			default: return BUBBLE;
		endcase
	endfunction

	function automatic status_t pick_bck_status();
		int r;
		r = $urandom_range(0, 3);
		case (r)
			0:       return BCK_INI;
			1:       return BCK_RUN;
			2:       return BCK_END;
			default: return BUBBLE;
		endcase
	endfunction

	// one falling edge worth of stimulus
	task automatic drive_cycle(bit active, int cycle);
		@(negedge Clk_32UI);
		fwd_in.status = active ? pick_fwd_status() : BUBBLE;
		fwd_in.ptr_curr = pos_t'($urandom);
		fwd_in.read_num = read_num_t'($urandom);
		fwd_in.ik_x0 = random_word();
		fwd_in.ik_x1 = random_word();
		fwd_in.ik_x2 = random_word();
		fwd_in.ik_info = random_word();
		fwd_in.forward_i = pos_t'($urandom);
		fwd_in.min_intv = pos_t'($urandom);
		fwd_in.backward_x = pos_t'($urandom);
		fwd_in.query = query_t'($urandom);
		next_query_position = query_t'($urandom);
		status_B = pick_bck_status();
		read_num_B = read_num_t'($urandom);
		output_c_B = query_t'($urandom);
		if (fwd_in.status inside {F_INIT, F_RUN})
			runs_sent++;
		dram_get = (bundles_sent < runs_sent) && (!active || $urandom_range(0, 1) == 1);
		if (dram_get) begin
			occ_in = {24{$urandom}};
			bundles_sent++;
		end
		stall = active && ($urandom_range(0, 9) == 0);
		load_done = active && (cycle >= 20);
		new_read_valid = active && ($urandom_range(0, 2) != 0);
		new_read_in = {read_num_t'($urandom), random_word(), random_word(),
			random_word(), random_word(), pos_t'($urandom)};
	endtask

	initial begin
		void'($urandom(32'hdab7_5e21));
		Clk_32UI = 1'b0;
		reset_n = 1'b0;
		stall = 1'b0;
		fwd_in = '1;
		fwd_in.status = BUBBLE;
		next_query_position = '0;
		status_B = BUBBLE;
		read_num_B = '0;
		output_c_B = '0;
		dram_get = 1'b0;
		occ_in = '0;
		new_read_valid = 1'b0;
		load_done = 1'b0;
		new_read_in = '0;
		query_data = '0;
		runs_sent = 0;
		bundles_sent = 0;
		for (int i = 0; i < QUERY_LATENCY; i++)
			answer_pipe[i] = '0;
		repeat (RESET_CYCLES) @(negedge Clk_32UI);
		reset_n = 1'b1;
		for (int c = 0; c < RAND_CYCLES; c++)
			drive_cycle(1'b1, c);
		// drain, no new traffic until every read is back out
		while (pending_reads != 0 || bundles_sent < runs_sent)
			drive_cycle(1'b0, 0);
		repeat (QUERY_LATENCY + 4) drive_cycle(1'b0, 0);
		if (error_seen) begin
			$display("Test failed");
			$fatal(1, "checks reported an error");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

	always @(posedge error_seen) begin
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	end

	// watchdog
	initial begin
		#(TEST_CYCLES * CLK_PERIOD * 2);
		$display("watchdog: run did not finish in time");
		$display("Test failed");
		$fatal(1, "timeout");
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the smem_queue testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module smem_queue_tb -o smem_queue_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/smem_queue_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Test passed" "$SIM_LOG"; then
	exit 0
fi
echo "pass line not found in $SIM_LOG"
exit 1

// File: tb.f
common/smem_queue_pkg.sv
design/entry_ring.sv
design/query_fetch/query_fetch.sv
design/read_dispatch/read_dispatch.sv
design/smem_queue.sv
dv/smem_queue_checks.sv
dv/smem_queue_tb.sv
